// ==== build.f ====
+incdir+.
ccx_bus_pkg.sv
ccx_csr_pkg.sv
ccx_mmio.sv
ccx_bus_router.sv
ccx_ram.sv
ccx_entropy_source.sv
ccx_top.sv
tb_ccx_clock.sv
tb_ccx.sv

// ==== ccx_bus_pkg.sv ====
package ccx_bus_pkg;

    typedef logic [31:0] addr_t; // Byte address.
    typedef logic [31:0] data_t; // One bus word.
    typedef logic [3:0]  strb_t; // One bit per byte lane.

    // Core-side request, one per cycle.
    typedef struct packed {
        logic  req;   // Request valid.
        logic  wen;   // Write enable.
        strb_t strb;  // Byte strobes for writes.
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // Response, valid one cycle after acceptance.
    typedef struct packed {
        logic  valid;
        logic  error;
        data_t rdata;
    } mem_rsp_t;

endpackage

// ==== ccx_bus_router.sv ====
`timescale 1ns/1ns
`include "ccx_macros.svh"

module ccx_bus_router
    import ccx_bus_pkg::*;
(
    input  logic     f_clk,
    input  logic     g_resetn,
    input  mem_req_t cpu_req,
    input  mem_rsp_t ram_rsp,
    input  mem_rsp_t mmio_rsp,
    output logic     cpu_gnt,
    output mem_rsp_t cpu_rsp,
    output mem_req_t ram_req,
    output mem_req_t mmio_req
);

    localparam addr_t RAM_MASK  = ~addr_t'(`RAM_SIZE - 1);
    localparam addr_t MMIO_MASK = ~addr_t'(`MMIO_SIZE - 1);

    logic  accept;
    logic  hit_ram;
    logic  hit_mmio;
    logic  pending;  // Response due this cycle.
    logic  sel_ram;
    logic  sel_mmio;
    logic  rsp_error;
    data_t rsp_rdata;

    assign cpu_gnt = 1'b1; // No back-pressure.
    assign accept  = cpu_req.req && cpu_gnt;

    assign hit_ram  = (cpu_req.addr & RAM_MASK)  == `RAM_BASE_ADDR;
    assign hit_mmio = (cpu_req.addr & MMIO_MASK) == `MMIO_BASE_ADDR;

    // Targets see the core request with req steered.
    always_comb begin
        ram_req      = cpu_req;
        ram_req.req  = accept && hit_ram;
        mmio_req     = cpu_req;
        mmio_req.req = accept && hit_mmio;
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            pending  <= 1'b0;
            sel_ram  <= 1'b0;
            sel_mmio <= 1'b0;
        end else begin
            pending  <= accept;
            sel_ram  <= accept && hit_ram;
            sel_mmio <= accept && hit_mmio;
        end
    end

    // Neither target selected means unmapped.
    assign rsp_error = sel_ram ? ram_rsp.error : (sel_mmio ? mmio_rsp.error : 1'b1);
    assign rsp_rdata = sel_ram ? ram_rsp.rdata : (sel_mmio ? mmio_rsp.rdata : '0);

    assign cpu_rsp = '{valid: pending, error: pending && rsp_error, rdata: rsp_rdata};

endmodule

// ==== ccx_csr_pkg.sv ====
package ccx_csr_pkg;

    typedef logic [63:0] ctr_t; // Full width counter.

    // Counter values seen by the core.
    typedef struct packed {
        ctr_t mtime;   // Memory mapped timer.
        ctr_t cycle;
        ctr_t instret;
    } ctr_values_t;

    // Poll status, encoded as in pollentropy.
    typedef enum logic [1:0] {
        BIST = 2'b00,
        WAIT = 2'b01,
        ES16 = 2'b10,
        DEAD = 2'b11
    } es_opst_t;

    // Entropy source FSM.
    typedef enum logic {
        ES_FILL,
        ES_READY
    } es_state_t;

    typedef logic [15:0] entropy_t; // One poll sample.

endpackage

// ==== ccx_entropy_source.sv ====
`timescale 1ns/1ns
`include "ccx_macros.svh"

module ccx_entropy_source
    import ccx_csr_pkg::*;
(
    input  logic     f_clk,
    input  logic     g_resetn,
    input  logic     trng_read,
    output es_opst_t es_opst,
    output entropy_t es_sample
);

    localparam int          CNT_W     = $clog2(`ES_REFILL_CYCLES + 1);
    localparam logic [31:0] LFSR_TAPS = 32'hB4BC_D35C; // Maximal length.

    logic [31:0]      lfsr;
    es_state_t        state;
    logic [CNT_W-1:0] refill_cnt;
    logic             bist_done;  // First fill has completed.
    entropy_t         sample_q;

    // Galois LFSR, shifts right every cycle.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            lfsr <= `ES_LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            state      <= ES_FILL;
            refill_cnt <= CNT_W'(`ES_REFILL_CYCLES - 1);
            bist_done  <= 1'b0;
        end else begin
            case (state)
                ES_FILL: begin
                    if (refill_cnt == '0) begin
                        state     <= ES_READY;
                        bist_done <= 1'b1;
                    end else begin
                        refill_cnt <= refill_cnt - 1'b1;
                    end
                end
                ES_READY: begin
                    if (trng_read) begin // Sample consumed, start over.
                        state      <= ES_FILL;
                        refill_cnt <= CNT_W'(`ES_REFILL_CYCLES - 1);
                    end
                end
                default: state <= ES_FILL;
            endcase
        end
    end

    // Sample taken as the FSM enters ES_READY.
    always_ff @(posedge f_clk) begin
        if (state == ES_FILL && refill_cnt == '0) begin
            sample_q <= lfsr[15:0];
        end
    end

    assign es_opst   = (state == ES_READY) ? ES16 : (bist_done ? WAIT : BIST);
    assign es_sample = (state == ES_READY) ? sample_q : '0; // Zero unless ES16.

endmodule

// ==== ccx_macros.svh ====
`ifndef CCX_MACROS_SVH
`define CCX_MACROS_SVH

// MMIO window of the core complex.
`define MMIO_BASE_ADDR      32'h0000_1000
`define MMIO_SIZE           32'h0000_0100

// Register offsets inside the MMIO window.
`define MMIO_MTIME_OFF      32'd0
`define MMIO_MTIMEH_OFF     32'd4
`define MMIO_MTIMECMP_OFF   32'd8
`define MMIO_MTIMECMPH_OFF  32'd12
`define MMIO_TRNG_OFF       32'd16

// Word RAM at the bottom of the map.
`define RAM_BASE_ADDR       32'h0000_0000
`define RAM_WORDS           1024
`define RAM_SIZE            (`RAM_WORDS * 4) // Bytes.

// Reset values and timing.
`define MTIMECMP_RESET      64'hFFFF_FFFF_FFFF_FFFF
`define ES_REFILL_CYCLES    8  // Cycles from poll read to next sample.
`define ES_LFSR_SEED        32'hACE1_5EED

`endif

// ==== ccx_mmio.sv ====
`timescale 1ns/1ns
`include "ccx_macros.svh"

module ccx_mmio
    import ccx_bus_pkg::*, ccx_csr_pkg::*;
(
    input  logic        f_clk,
    input  logic        g_resetn,
    input  mem_req_t    mmio_req,
    input  logic        instr_ret,
    input  logic        inhibit_cy,
    input  logic        inhibit_ir,
    input  es_opst_t    es_opst,
    input  entropy_t    es_sample,
    output mem_rsp_t    mmio_rsp,
    output logic        timer_interrupt,
    output ctr_values_t ctr,
    output logic        trng_read
);

    localparam addr_t MMIO_MASK = `MMIO_SIZE - 1;

    addr_t offset;
    logic  sel_mtime_lo;
    logic  sel_mtime_hi;
    logic  sel_cmp_lo;
    logic  sel_cmp_hi;
    logic  sel_trng;
    logic  wr;
    data_t poll_word;
    data_t n_rdata;
    logic  n_error;

    ctr_t  mtime_q;
    ctr_t  mtimecmp_q;
    ctr_t  cycle_q;
    ctr_t  instret_q;
    logic  rsp_error;
    data_t rsp_rdata;

    assign offset = mmio_req.addr & MMIO_MASK;

    // Register selects, qualified by the routed request.
    assign sel_mtime_lo = mmio_req.req && (offset == `MMIO_MTIME_OFF);
    assign sel_mtime_hi = mmio_req.req && (offset == `MMIO_MTIMEH_OFF);
    assign sel_cmp_lo   = mmio_req.req && (offset == `MMIO_MTIMECMP_OFF);
    assign sel_cmp_hi   = mmio_req.req && (offset == `MMIO_MTIMECMPH_OFF);
    assign sel_trng     = mmio_req.req && (offset == `MMIO_TRNG_OFF);

    assign wr = mmio_req.wen;

    assign trng_read = sel_trng; // Any access consumes the sample.

    assign poll_word = {es_opst, 14'b0, es_sample};

    // Timer. A half write replaces that half for the cycle.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mtime_q <= '0;
        end else if (sel_mtime_hi && wr) begin
            mtime_q <= {mmio_req.wdata, mtime_q[31:0]};
        end else if (sel_mtime_lo && wr) begin
            mtime_q <= {mtime_q[63:32], mmio_req.wdata};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mtimecmp_q <= `MTIMECMP_RESET;
        end else if (sel_cmp_hi && wr) begin
            mtimecmp_q <= {mmio_req.wdata, mtimecmp_q[31:0]};
        end else if (sel_cmp_lo && wr) begin
            mtimecmp_q <= {mtimecmp_q[63:32], mmio_req.wdata};
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            timer_interrupt <= 1'b0;
        end else begin
            timer_interrupt <= (mtime_q >= mtimecmp_q); // One cycle behind.
        end
    end

    // Cycle and instret counters.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            cycle_q <= '0;
        end else if (!inhibit_cy) begin
            cycle_q <= cycle_q + 64'd1;
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            instret_q <= '0;
        end else if (instr_ret && !inhibit_ir) begin
            instret_q <= instret_q + 64'd1;
        end
    end

    assign ctr = '{mtime: mtime_q, cycle: cycle_q, instret: instret_q};

    // Read mux, one-hot selects.
    assign n_rdata = ({32{sel_mtime_lo}} & mtime_q[31:0])
                   | ({32{sel_mtime_hi}} & mtime_q[63:32])
                   | ({32{sel_cmp_lo}}   & mtimecmp_q[31:0])
                   | ({32{sel_cmp_hi}}   & mtimecmp_q[63:32])
                   | ({32{sel_trng}}     & poll_word);

    // Hole inside the window.
    assign n_error = mmio_req.req
                   && !(sel_mtime_lo || sel_mtime_hi || sel_cmp_lo || sel_cmp_hi || sel_trng);

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            rsp_error <= 1'b0;
        end else if (mmio_req.req) begin
            rsp_error <= n_error;
        end
    end

    always_ff @(posedge f_clk) begin
        if (mmio_req.req) begin
            rsp_rdata <= n_rdata;
        end
    end

    // Router supplies valid.
    assign mmio_rsp = '{valid: 1'b0, error: rsp_error, rdata: rsp_rdata};

endmodule

// ==== ccx_ram.sv ====
`timescale 1ns/1ns
`include "ccx_macros.svh"

module ccx_ram
    import ccx_bus_pkg::*;
(
    input  logic     f_clk,
    input  logic     g_resetn,
    input  mem_req_t ram_req,
    output mem_rsp_t ram_rsp
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    data_t            mem [`RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             do_write;
    logic             bad_write;
    logic             rsp_error;
    data_t            rsp_rdata;

    assign idx       = ram_req.addr[IDX_W+1:2]; // Word index.
    assign bad_write = ram_req.req && ram_req.wen && (ram_req.strb == '0);
    assign do_write  = ram_req.req && ram_req.wen && !bad_write;

    // Byte lane writes.
    always_ff @(posedge f_clk) begin
        if (do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.strb[i]) begin
                    mem[idx][i*8 +: 8] <= ram_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge f_clk) begin
        if (ram_req.req && !ram_req.wen) begin
            rsp_rdata <= mem[idx];
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            rsp_error <= 1'b0;
        end else if (ram_req.req) begin
            rsp_error <= bad_write;
        end
    end

    assign ram_rsp = '{valid: 1'b0, error: rsp_error, rdata: rsp_rdata};

endmodule

// ==== ccx_top.sv ====
`timescale 1ns/1ns

module ccx_top
    import ccx_bus_pkg::*, ccx_csr_pkg::*;
(
    input  logic        f_clk,
    input  logic        g_resetn,
    input  mem_req_t    cpu_req,
    input  logic        instr_ret,
    input  logic        inhibit_cy,
    input  logic        inhibit_ir,
    output logic        cpu_gnt,
    output mem_rsp_t    cpu_rsp,
    output logic        timer_interrupt,
    output ctr_values_t ctr
);

    mem_req_t ram_req;
    mem_req_t mmio_req;
    mem_rsp_t ram_rsp;
    mem_rsp_t mmio_rsp;
    logic     trng_read;
    es_opst_t es_opst;
    entropy_t es_sample;

    ccx_bus_router ccx_bus_router_inst (
        .f_clk    (f_clk),
        .g_resetn (g_resetn),
        .cpu_req  (cpu_req),
        .ram_rsp  (ram_rsp),
        .mmio_rsp (mmio_rsp),
        .cpu_gnt  (cpu_gnt),
        .cpu_rsp  (cpu_rsp),
        .ram_req  (ram_req),
        .mmio_req (mmio_req)
    );

    ccx_ram ccx_ram_inst (
        .f_clk    (f_clk),
        .g_resetn (g_resetn),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    // Timer, counters and poll register.
    ccx_mmio ccx_mmio_inst (
        .f_clk           (f_clk),
        .g_resetn        (g_resetn),
        .mmio_req        (mmio_req),
        .instr_ret       (instr_ret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_ir      (inhibit_ir),
        .es_opst         (es_opst),
        .es_sample       (es_sample),
        .mmio_rsp        (mmio_rsp),
        .timer_interrupt (timer_interrupt),
        .ctr             (ctr),
        .trng_read       (trng_read)
    );

    ccx_entropy_source ccx_entropy_source_inst (
        .f_clk     (f_clk),
        .g_resetn  (g_resetn),
        .trng_read (trng_read),
        .es_opst   (es_opst),
        .es_sample (es_sample)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ccx -f build.f -o sim_ccx

./obj_dir/sim_ccx > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log

// ==== tb_ccx.sv ====
`timescale 1ns/1ns
`include "ccx_macros.svh"

module tb_ccx
    import ccx_bus_pkg::*, ccx_csr_pkg::*;
();

    localparam int    MAX_CYCLES     = 2000; // Well above the length of all tests.
    localparam int    RAM_TESTS      = 8;
    localparam addr_t MTIME_ADDR     = `MMIO_BASE_ADDR + `MMIO_MTIME_OFF;
    localparam addr_t MTIMEH_ADDR    = `MMIO_BASE_ADDR + `MMIO_MTIMEH_OFF;
    localparam addr_t MTIMECMP_ADDR  = `MMIO_BASE_ADDR + `MMIO_MTIMECMP_OFF;
    localparam addr_t MTIMECMPH_ADDR = `MMIO_BASE_ADDR + `MMIO_MTIMECMPH_OFF;
    localparam addr_t TRNG_ADDR      = `MMIO_BASE_ADDR + `MMIO_TRNG_OFF;

    logic        f_clk;
    logic        g_resetn;
    mem_req_t    cpu_req;
    logic        instr_ret;
    logic        inhibit_cy;
    logic        inhibit_ir;
    logic        cpu_gnt;
    mem_rsp_t    cpu_rsp;
    logic        timer_interrupt;
    ctr_values_t ctr;

    int     cycle_cnt = 0;
    integer seed;

    tb_ccx_clock tb_ccx_clock_inst (.f_clk(f_clk));

    ccx_top ccx_top_inst (
        .f_clk           (f_clk),
        .g_resetn        (g_resetn),
        .cpu_req         (cpu_req),
        .instr_ret       (instr_ret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_ir      (inhibit_ir),
        .cpu_gnt         (cpu_gnt),
        .cpu_rsp         (cpu_rsp),
        .timer_interrupt (timer_interrupt),
        .ctr             (ctr)
    );

    always @(posedge f_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic within_range(input string name, input logic [63:0] got,
                                input logic [63:0] lo, input logic [63:0] hi);
        assert (got >= lo && got <= hi) else begin
            $display("Fail at %0t ns: %s is %0h, expected %0h to %0h", $time, name, got, lo, hi);
            abort_run();
        end
    endtask

    // Response must follow the accept by exactly one cycle.
    task automatic issue_request(input logic wen, input strb_t strb, input addr_t addr,
                                 input data_t wdata, output data_t rdata, output logic error);
        @(negedge f_clk);
        expect_equal("cpu_rsp.valid", cpu_rsp.valid, 0);
        expect_equal("cpu_gnt", cpu_gnt, 1);
        cpu_req = '{req: 1'b1, wen: wen, strb: strb, addr: addr, wdata: wdata};
        @(negedge f_clk);
        cpu_req.req = 1'b0;
        expect_equal("cpu_rsp.valid", cpu_rsp.valid, 1);
        rdata = cpu_rsp.rdata;
        error = cpu_rsp.error;
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t strb,
                             output logic error);
        data_t unused_rdata;
        issue_request(1'b1, strb, addr, wdata, unused_rdata, error);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata, output logic error);
        issue_request(1'b0, 4'h0, addr, 32'h0, rdata, error);
    endtask

    task automatic retire_pulses(input int n);
        repeat (n) begin
            instr_ret = 1'b1;
            @(negedge f_clk);
            instr_ret = 1'b0;
            @(negedge f_clk);
        end
    endtask

    task automatic reset_state();
        int start;
        int elapsed;
        expect_equal("timer_interrupt", timer_interrupt, 0);
        expect_equal("cpu_rsp.valid", cpu_rsp.valid, 0);
        expect_equal("cpu_rsp.error", cpu_rsp.error, 0);
        expect_equal("cpu_gnt", cpu_gnt, 1);
        start = cycle_cnt;
        repeat (3) @(negedge f_clk);
        elapsed = cycle_cnt - start;
        within_range("ctr.cycle", ctr.cycle, 0, elapsed);
        within_range("ctr.mtime", ctr.mtime, 0, elapsed);
        within_range("ctr.instret", ctr.instret, 0, elapsed);
    endtask

    task automatic ram_and_decode();
        addr_t addr [RAM_TESTS];
        data_t exp  [RAM_TESTS];
        data_t rdata;
        logic  error;
        for (int i = 0; i < RAM_TESTS; i++) begin
            addr[i] = `RAM_BASE_ADDR + addr_t'(i) * 32'h1FC; // Spread over the RAM.
            exp[i]  = $random(seed);
            bus_write(addr[i], exp[i], 4'hF, error);
            expect_equal("cpu_rsp.error", error, 0);
        end
        for (int i = 0; i < RAM_TESTS; i++) begin
            bus_read(addr[i], rdata, error);
            expect_equal("cpu_rsp.rdata", rdata, exp[i]);
            expect_equal("cpu_rsp.error", error, 0);
        end
        bus_write(addr[0], 32'hA55A_C33C, 4'b0100, error); // Byte lane 2 only.
        exp[0] = {exp[0][31:24], 8'h5A, exp[0][15:0]};
        bus_read(addr[0], rdata, error);
        expect_equal("cpu_rsp.rdata", rdata, exp[0]);
        bus_write(addr[1], ~exp[1], 4'h0, error);
        expect_equal("cpu_rsp.error", error, 1);
        bus_read(addr[1], rdata, error);
        expect_equal("cpu_rsp.rdata", rdata, exp[1]); // Memory untouched.
        bus_read(32'h0000_2000, rdata, error);
        expect_equal("cpu_rsp.error", error, 1);
        expect_equal("cpu_rsp.rdata", rdata, 0);
    endtask

    task automatic mtime_access();
        data_t wval;
        data_t rdata;
        logic  error;
        wval = 32'h0001_0000;
        bus_write(MTIME_ADDR, wval, 4'hF, error);
        expect_equal("cpu_rsp.error", error, 0);
        bus_write(MTIMEH_ADDR, 32'h0, 4'hF, error);
        bus_read(MTIME_ADDR, rdata, error);
        within_range("mtime low", rdata, wval, wval + 10);
        bus_read(MTIMEH_ADDR, rdata, error);
        expect_equal("mtime high", rdata, 0);
        within_range("ctr.mtime", ctr.mtime, wval, wval + 10);
        bus_read(`MMIO_BASE_ADDR + 32'h18, rdata, error); // Hole in the window.
        expect_equal("cpu_rsp.error", error, 1);
    endtask

    task automatic timer_irq();
        data_t cur;
        logic  error;
        logic  seen;
        bus_read(MTIME_ADDR, cur, error);
        bus_write(MTIMECMP_ADDR, cur + 32'd40, 4'hF, error);
        bus_write(MTIMECMPH_ADDR, 32'h0, 4'hF, error);
        repeat (30) begin
            @(negedge f_clk);
            expect_equal("timer_interrupt", timer_interrupt, 0);
        end
        seen = 1'b0;
        for (int i = 0; i < 20 && !seen; i++) begin
            @(negedge f_clk);
            seen = timer_interrupt;
        end
        assert (seen) else begin
            $display("Timer interrupt did not rise within 20 cycles at %0t ns.", $time);
            abort_run();
        end
        repeat (5) begin
            @(negedge f_clk);
            expect_equal("timer_interrupt", timer_interrupt, 1);
        end
        bus_write(MTIMECMPH_ADDR, 32'hFFFF_FFFF, 4'hF, error);
        repeat (2) @(negedge f_clk);
        expect_equal("timer_interrupt", timer_interrupt, 0);
    endtask

    task automatic counter_inhibits();
        ctr_t base;
        @(negedge f_clk);
        base = ctr.instret;
        retire_pulses(7);
        expect_equal("ctr.instret", ctr.instret, base + 7);
        inhibit_ir = 1'b1;
        base = ctr.instret;
        retire_pulses(7);
        expect_equal("ctr.instret", ctr.instret, base);
        inhibit_ir = 1'b0;
        inhibit_cy = 1'b1;
        base = ctr.cycle;
        repeat (10) @(negedge f_clk);
        expect_equal("ctr.cycle", ctr.cycle, base);
        inhibit_cy = 1'b0;
        base = ctr.cycle;
        repeat (10) @(negedge f_clk);
        expect_equal("ctr.cycle", ctr.cycle, base + 10);
    endtask

    task automatic entropy_poll();
        data_t    rdata;
        logic     error;
        entropy_t first_sample;
        repeat (`ES_REFILL_CYCLES + 2) @(negedge f_clk);
        bus_read(TRNG_ADDR, rdata, error);
        expect_equal("poll status", rdata[31:30], ES16);
        expect_equal("poll reserved", rdata[29:16], 0);
        expect_equal("cpu_rsp.error", error, 0);
        first_sample = rdata[15:0];
        bus_read(TRNG_ADDR, rdata, error); // Sample already consumed.
        expect_equal("poll status", rdata[31:30], WAIT);
        expect_equal("poll sample", rdata[15:0], 0);
        repeat (`ES_REFILL_CYCLES + 2) @(negedge f_clk);
        bus_read(TRNG_ADDR, rdata, error);
        expect_equal("poll status", rdata[31:30], ES16);
        assert (rdata[15:0] !== first_sample) else begin
            $display("Entropy sample did not change between polls at %0t ns.", $time);
            abort_run();
        end
    endtask

    initial begin
        seed       = 35641;
        g_resetn   = 1'b0;
        cpu_req    = '0;
        instr_ret  = 1'b0;
        inhibit_cy = 1'b0;
        inhibit_ir = 1'b0;
        repeat (16) @(negedge f_clk);
        g_resetn = 1'b1;
        reset_state();
        ram_and_decode();
        mtime_access();
        timer_irq();
        counter_inhibits();
        entropy_poll();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb_ccx_clock.sv ====
`timescale 1ns/1ns

module tb_ccx_clock (
    output logic f_clk
);

    // 4 ns period.
    initial begin
        f_clk = 1'b0;
        forever begin
            #2 f_clk = ~f_clk;
        end
    end

endmodule
